//--- compile.f
+incdir+common
+incdir+tb
common/desc_kick_pkg.sv
desc_kick/kick_sequencer.sv
desc_kick/kick_channel_route.sv
src/desc_kickoff_router.sv
tb/tb_desc_kickoff_router.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the kick-off router testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log
obj_dir=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
        -f compile.f --top-module tb_desc_kickoff_router \
        --Mdir "$obj_dir" -o tb_sim > "$build_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
        cat "$build_log"
        echo "Verilator build failed with status $status"
        exit 1
fi

"./$obj_dir/tb_sim" > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
        echo "Simulation exited with status $status"
        exit 1
fi

if grep -qF "*** TEST FAILED ***" "$sim_log"; then
        exit 1
fi
exit 0

//--- tb/kick_tasks.svh
// Testbench tasks: timeout report, command driver, response wait, pair and error sequences
`ifndef KICK_TASKS_SVH
`define KICK_TASKS_SVH

task automatic note_timeout(input string what);
        timeouts++;
        $display("TIMEOUT in test %s: gave up waiting for %s", test_name, what);
endtask

// Drives one command on a falling edge once cmd_ready is up, drops it a cycle later
task automatic send_command(input cmd_addr_t address, input cmd_data_t data,
                            input logic is_write);
        int wait_cycles;
        wait_cycles = 0;
        while (!cmd_ready && wait_cycles < cmd_timeout) begin
                @(negedge clk);
                wait_cycles++;
        end
        if (!cmd_ready) begin
                note_timeout("cmd_ready");
        end else begin
                cmd_valid = 1'b1;
                cmd       = '{addr: address, wdata: data, write: is_write};
                @(negedge clk);
                cmd_valid = 1'b0;
                cmd       = '0;
        end
endtask

// Returns on the falling edge after the next response handshake
task automatic wait_response();
        int start_count;
        int wait_cycles;
        start_count = rsp_count;
        wait_cycles = 0;
        while (rsp_count == start_count && wait_cycles < rsp_timeout) begin
                @(negedge clk);
                wait_cycles++;
        end
        if (rsp_count == start_count)
                note_timeout("response handshake");
endtask

// Clean LOW then HIGH pair, random upper address bits outside the decode
task automatic run_pair(input chan_id_t ch, input cmd_data_t lo, input cmd_data_t hi,
                        input string name);
        cmd_addr_t base;
        base           = ($urandom & 32'hffff_f000) | (cmd_addr_t'(ch) << 3);
        test_name      = name;
        exp_error      = 1'b0;
        expect_route   = 1'b0;
        expect_hit_rsp = 1'b0;
        send_command(base, lo, 1'b1);
        wait_response();
        // HIGH word sits above LOW word on the selected engine
        exp_chan       = ch;
        exp_addr       = {hi, lo};
        expect_route   = 1'b1;
        expect_hit_rsp = 1'b1;
        send_command(base | 32'h4, hi, 1'b1);
        wait_response();
        expect_route   = 1'b0;
        expect_hit_rsp = 1'b0;
endtask

// Single command in idle that must come back with an error
task automatic run_bad_command(input cmd_addr_t address, input logic is_write,
                               input string name);
        test_name = name;
        exp_error = 1'b1;
        send_command(address, $urandom, is_write);
        wait_response();
        exp_error = 1'b0;
endtask

// Good LOW write, bad second command, then a clean pair on the same channel
task automatic run_broken_pair(input chan_id_t ch, input cmd_addr_t second_addr,
                               input logic second_write, input string name);
        test_name = name;
        exp_error = 1'b0;
        send_command(cmd_addr_t'(ch) << 3, $urandom, 1'b1);
        wait_response();
        exp_error = 1'b1;
        send_command(second_addr, $urandom, second_write);
        wait_response();
        run_pair(ch, $urandom, $urandom, name);
endtask

`endif

//--- tb/tb_desc_kickoff_router.sv
// Testbench top with clock, reset, engine and response models, checking assertions and test sequence
`timescale 1ns/1ps
`default_nettype none

`include "desc_kick_settings.svh"

module tb_desc_kickoff_router;
        import desc_kick_pkg::*;

        localparam int cmd_timeout   = 20;
        localparam int rsp_timeout   = 80;
        localparam int route_timeout = 40;

        logic       clk;
        logic       reset;
        logic       cmd_valid;
        apb_cmd_t   cmd;
        logic       cmd_ready;
        logic       rsp_valid;
        logic       rsp_ready = 1'b0;
        logic       rsp_error;
        chan_mask_t desc_valid;
        chan_mask_t desc_ready = '0;
        desc_addr_t [`DK_NUM_CHANNELS-1:0] desc_addr;
        logic       kickoff_hit;

        // Expected response and routing as set by the tasks before each command
        string      test_name      = "reset";
        logic       exp_error      = 1'b0;
        logic       expect_route   = 1'b0;
        logic       expect_hit_rsp = 1'b0;
        chan_id_t   exp_chan       = '0;
        desc_addr_t exp_addr       = '0;

        // Engine stall control and bookkeeping
        chan_mask_t engine_hold = '0;
        int         engine_delay [`DK_NUM_CHANNELS];
        int         rsp_count = 0;
        int         errors    = 0;
        int         timeouts  = 0;
        int         waited;

        desc_kickoff_router uut (
                .clk         (clk),
                .reset       (reset),
                .cmd_valid   (cmd_valid),
                .cmd         (cmd),
                .cmd_ready   (cmd_ready),
                .rsp_valid   (rsp_valid),
                .rsp_ready   (rsp_ready),
                .rsp_error   (rsp_error),
                .desc_valid  (desc_valid),
                .desc_ready  (desc_ready),
                .desc_addr   (desc_addr),
                .kickoff_hit (kickoff_hit)
        );

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        // ==================================================================
        // Engine and response models
        // ==================================================================

        // Each engine takes the pointer 0 to 5 cycles after valid unless held
        always @(negedge clk) begin
                for (int c = 0; c < `DK_NUM_CHANNELS; c++) begin
                        if (!desc_valid[c]) begin
                                desc_ready[c]   = 1'b0;
                                engine_delay[c] = $urandom % 6;
                        end else if (engine_hold[c]) begin
                                desc_ready[c] = 1'b0;
                        end else if (engine_delay[c] == 0) begin
                                desc_ready[c] = 1'b1;
                        end else begin
                                engine_delay[c] = engine_delay[c] - 1;
                        end
                end
        end

        // Response side ready about two cycles in three
        always @(negedge clk)
                rsp_ready = ($urandom % 3) != 0;

        always @(posedge clk)
                if (rsp_valid && rsp_ready)
                        rsp_count <= rsp_count + 1;

        // ==================================================================
        // Checking
        // ==================================================================

        function automatic chan_mask_t one_hot_of(input chan_id_t ch);
                return chan_mask_t'(1) << ch;
        endfunction

        function automatic void note_mismatch(input string what, input logic [63:0] exp_val,
                                              input logic [63:0] act_val);
                errors++;
                $display("CHECK FAILED test=%s check=%s expected=%h actual=%h",
                         test_name, what, exp_val, act_val);
        endfunction

        // Idle outputs on the first edge out of reset
        a_reset_outputs: assert property (@(posedge clk)
                $fell(reset) |-> cmd_ready && !rsp_valid && desc_valid == '0 && !kickoff_hit)
                else note_mismatch("reset outputs", 64'h400,
                        64'({$sampled(cmd_ready), $sampled(rsp_valid),
                             $sampled(desc_valid), $sampled(kickoff_hit)}));

        a_reset_addr: assert property (@(posedge clk)
                $fell(reset) |-> desc_addr == '0)
                else note_mismatch("reset desc_addr", 64'h0, $sampled(desc_addr[0]));

        a_rsp_error: assert property (@(posedge clk) disable iff (reset)
                rsp_valid |-> rsp_error == exp_error)
                else note_mismatch("rsp_error", 64'(exp_error), 64'($sampled(rsp_error)));

        // Anything but a clean HIGH write is answered on the next cycle
        a_cmd_to_rsp: assert property (@(posedge clk) disable iff (reset)
                cmd_valid && cmd_ready && !expect_route |=> rsp_valid)
                else note_mismatch("rsp_valid after command", 64'h1, 64'($sampled(rsp_valid)));

        a_high_to_route: assert property (@(posedge clk) disable iff (reset)
                cmd_valid && cmd_ready && expect_route |=> desc_valid == one_hot_of(exp_chan))
                else note_mismatch("desc_valid after HIGH", 64'(one_hot_of(exp_chan)),
                                   64'($sampled(desc_valid)));

        // Only the selected engine and only after a clean pair
        a_valid_target: assert property (@(posedge clk) disable iff (reset)
                (|desc_valid) |-> expect_route && desc_valid == one_hot_of(exp_chan))
                else note_mismatch("desc_valid target",
                                   expect_route ? 64'(one_hot_of(exp_chan)) : 64'h0,
                                   64'($sampled(desc_valid)));

        a_desc_addr: assert property (@(posedge clk) disable iff (reset)
                (|desc_valid) |-> desc_addr[exp_chan] == exp_addr)
                else note_mismatch("desc_addr", exp_addr, $sampled(desc_addr[exp_chan]));

        // Engine back-pressure
        a_valid_hold: assert property (@(posedge clk) disable iff (reset)
                (|desc_valid) && !(|(desc_valid & desc_ready)) |=>
                        desc_valid == one_hot_of(exp_chan) && $stable(desc_addr))
                else note_mismatch("desc_valid hold", exp_addr, $sampled(desc_addr[exp_chan]));

        a_no_rsp_in_route: assert property (@(posedge clk) disable iff (reset)
                (|desc_valid) |-> !rsp_valid)
                else note_mismatch("rsp_valid during route", 64'h0, 64'($sampled(rsp_valid)));

        a_accept_to_rsp: assert property (@(posedge clk) disable iff (reset)
                (|(desc_valid & desc_ready)) |=> rsp_valid && !rsp_error && desc_valid == '0)
                else note_mismatch("response after accept", 64'h2,
                        64'({$sampled(rsp_valid), $sampled(rsp_error)}));

        // One response per command
        a_single_rsp: assert property (@(posedge clk) disable iff (reset)
                rsp_valid && rsp_ready |=> !rsp_valid)
                else note_mismatch("rsp_valid after handshake", 64'h0,
                                   64'($sampled(rsp_valid)));

        a_kickoff_hit: assert property (@(posedge clk) disable iff (reset)
                kickoff_hit == ((|desc_valid) || (rsp_valid && expect_hit_rsp)))
                else note_mismatch("kickoff_hit",
                        64'((|desc_valid) || (rsp_valid && expect_hit_rsp)),
                        64'($sampled(kickoff_hit)));

        // Response back-pressure
        a_rsp_hold: assert property (@(posedge clk) disable iff (reset)
                rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_error))
                else note_mismatch("rsp hold", 64'({1'b1, exp_error}),
                                   64'({$sampled(rsp_valid), $sampled(rsp_error)}));

        a_no_cmd_during_rsp: assert property (@(posedge clk) disable iff (reset)
                rsp_valid |-> !cmd_ready)
                else note_mismatch("cmd_ready during response", 64'h0,
                                   64'($sampled(cmd_ready)));

        `include "kick_tasks.svh"

        // ==================================================================
        // Test sequence
        // ==================================================================

        initial begin
                void'($urandom(32'h1ff50393));
                reset     = 1'b1;
                cmd_valid = 1'b0;
                cmd       = '0;
                repeat (2) @(posedge clk);
                @(negedge clk);
                reset = 1'b0;

                // Every channel once
                for (int c = 0; c < `DK_NUM_CHANNELS; c++)
                        run_pair(chan_id_t'(c), $urandom, $urandom, "valid_pair");

                // Channel 5 stalls for several cycles once its valid is up
                @(posedge clk);
                engine_hold[5] = 1'b1;
                @(negedge clk);
                fork
                        run_pair(chan_id_t'(5), 32'h1357_9bdf, 32'h2468_ace0,
                                 "engine_backpressure");
                        begin
                                waited = 0;
                                while (!desc_valid[5] && waited < route_timeout) begin
                                        @(negedge clk);
                                        waited++;
                                end
                                if (!desc_valid[5])
                                        note_timeout("desc_valid on channel 5");
                                repeat (6) @(posedge clk);
                                engine_hold = '0;
                        end
                join

                run_bad_command(32'h0000_0010, 1'b0, "read_idle");
                run_bad_command(32'h0000_001c, 1'b1, "high_first");
                run_bad_command(32'h0000_0048, 1'b1, "low_out_of_range");
                run_bad_command(32'h0000_0ff0, 1'b1, "low_far_out_of_range");

                // Bad second command with a recovery pair on the same channel
                run_broken_pair(chan_id_t'(2), 32'h0000_0010, 1'b1, "second_low");
                run_broken_pair(chan_id_t'(4), 32'h0000_002c, 1'b1, "high_wrong_channel");
                run_broken_pair(chan_id_t'(6), 32'h0000_0034, 1'b0, "read_wait_high");
                run_broken_pair(chan_id_t'(7), 32'h0000_013c, 1'b1, "high_out_of_range");

                repeat (4) @(negedge clk);
                $display("Check failures: %0d, timeouts: %0d", errors, timeouts);
                if (errors == 0 && timeouts == 0) begin
                        $display("*** TEST PASSED ***");
                end else begin
                        $display("*** TEST FAILED ***");
                end
                $finish;
        end

endmodule

`default_nettype wire

//--- src/desc_kickoff_router.sv
// Top level of the descriptor kick-off router: sequencer plus channel router
`timescale 1ns/1ps
`default_nettype none

`include "desc_kick_settings.svh"

module desc_kickoff_router (
        input  logic                      clk,
        input  logic                      reset,
        // Command port from the register block
        input  logic                      cmd_valid,
        input  desc_kick_pkg::apb_cmd_t   cmd,
        output logic                      cmd_ready,
        // Response port
        output logic                      rsp_valid,
        input  logic                      rsp_ready,
        output logic                      rsp_error,
        // Descriptor engine kick-off ports
        output desc_kick_pkg::chan_mask_t desc_valid,
        input  desc_kick_pkg::chan_mask_t desc_ready,
        output desc_kick_pkg::desc_addr_t [`DK_NUM_CHANNELS-1:0] desc_addr,
        // Response mux select for the parent
        output logic                      kickoff_hit
);
        import desc_kick_pkg::*;

        // Sequencer to router
        logic      load_low;
        logic      load_high;
        cmd_data_t wdata;
        logic      route_active;
        chan_id_t  route_chan;

        // ==============================================================
        // Pair sequencing and handshakes
        // ==============================================================

        kick_sequencer u_sequencer (
                .clk          (clk),
                .reset        (reset),
                .cmd_valid    (cmd_valid),
                .cmd          (cmd),
                .cmd_ready    (cmd_ready),
                .rsp_valid    (rsp_valid),
                .rsp_ready    (rsp_ready),
                .rsp_error    (rsp_error),
                .desc_ready   (desc_ready),
                .load_low     (load_low),
                .load_high    (load_high),
                .wdata        (wdata),
                .route_active (route_active),
                .route_chan   (route_chan),
                .kickoff_hit  (kickoff_hit)
        );

        // ==============================================================
        // Pointer assembly and channel demux
        // ==============================================================

        kick_channel_route u_route (
                .clk          (clk),
                .reset        (reset),
                .load_low     (load_low),
                .load_high    (load_high),
                .wdata        (wdata),
                .route_active (route_active),
                .route_chan   (route_chan),
                .desc_valid   (desc_valid),
                .desc_addr    (desc_addr)
        );

endmodule

`default_nettype wire

//--- desc_kick/kick_channel_route.sv
// Channel router: LOW/HIGH word registers, 64-bit pointer assembly, per-channel valid demux
`timescale 1ns/1ps
`default_nettype none

`include "desc_kick_settings.svh"

module kick_channel_route (
        input  logic                      clk,
        input  logic                      reset,
        // Capture strobes and data from the sequencer
        input  logic                      load_low,
        input  logic                      load_high,
        input  desc_kick_pkg::cmd_data_t  wdata,
        // Routing control
        input  logic                      route_active,
        input  desc_kick_pkg::chan_id_t   route_chan,
        // Toward the descriptor engines
        output desc_kick_pkg::chan_mask_t desc_valid,
        output desc_kick_pkg::desc_addr_t [`DK_NUM_CHANNELS-1:0] desc_addr
);
        import desc_kick_pkg::*;

        cmd_data_t  low_q;
        cmd_data_t  high_q;
        desc_addr_t desc_word;

        // ==============================================================
        // Word capture
        // ==============================================================

        always_ff @(posedge clk) begin
                if (reset) begin
                        low_q  <= '0;
                        high_q <= '0;
                end else begin
                        if (load_low)
                                low_q <= wdata;
                        if (load_high)
                                high_q <= wdata;
                end
        end

        // HIGH word forms the upper half
        assign desc_word = {high_q, low_q};

        // ==============================================================
        // Engine outputs
        // ==============================================================

        // Same pointer on every channel, valid picks the target
        always_comb begin
                for (int ch = 0; ch < `DK_NUM_CHANNELS; ch++)
                        desc_addr[ch] = desc_word;
        end

        always_comb begin
                desc_valid = '0;
                if (route_active)
                        desc_valid[route_chan] = 1'b1;
        end

        // ==============================================================
        // Assertions
        // ==============================================================

        // At most one engine is addressed at a time
        a_valid_onehot0: assert property (
                @(posedge clk) disable iff (reset)
                $onehot0(desc_valid));

        // Pointer must not move while an engine is still being offered it
        a_addr_stable: assert property (
                @(posedge clk) disable iff (reset)
                (|desc_valid) ##1 (|desc_valid) |-> $stable(desc_word));

endmodule

`default_nettype wire

//--- desc_kick/kick_sequencer.sv
// Kick-off sequencer: address decode, pair-tracking FSM, error flag, channel latch, handshakes
`timescale 1ns/1ps
`default_nettype none

`include "desc_kick_settings.svh"

module kick_sequencer (
        input  logic                     clk,
        input  logic                     reset,
        // Command port from the register block
        input  logic                     cmd_valid,
        input  desc_kick_pkg::apb_cmd_t  cmd,
        output logic                     cmd_ready,
        // Response port
        output logic                     rsp_valid,
        input  logic                     rsp_ready,
        output logic                     rsp_error,
        // Accept strobes from the descriptor engines
        input  desc_kick_pkg::chan_mask_t desc_ready,
        // Toward the channel router
        output logic                     load_low,
        output logic                     load_high,
        output desc_kick_pkg::cmd_data_t wdata,
        output logic                     route_active,
        output desc_kick_pkg::chan_id_t  route_chan,
        output logic                     kickoff_hit
);
        import desc_kick_pkg::*;

        // Channel field sits just above the word-select bit
        localparam int chan_lsb = 3;
        localparam int chan_msb = chan_lsb + $bits(chan_id_t) - 1;
        localparam logic [`DK_DECODE_BITS-1:0] window_limit =
                `DK_DECODE_BITS'(`DK_WINDOW_BYTES);

        kick_state_t state;
        kick_state_t state_next;
        chan_id_t    chan_q;
        logic        err_q;

        chan_id_t    dec_chan;
        word_sel_t   dec_word;
        logic        in_range;
        logic        cmd_fire;
        logic        low_ok;
        logic        high_ok;

        // ==============================================================
        // Address decode
        // ==============================================================

        assign dec_chan = cmd.addr[chan_msb:chan_lsb];
        assign dec_word = word_sel_t'(cmd.addr[2]);
        // Only the low 12 bits are compared against the window
        assign in_range = cmd.addr[`DK_DECODE_BITS-1:0] < window_limit;

        assign cmd_fire = cmd_valid && cmd_ready;

        // Opening word of a pair
        assign low_ok  = cmd.write && in_range && (dec_word == word_low);
        // Closing word: same channel as the latched LOW write
        assign high_ok = cmd.write && in_range && (dec_word == word_high)
                         && (dec_chan == chan_q);

        // ==============================================================
        // FSM
        // ==============================================================

        always_comb begin
                state_next = state;
                case (state)
                st_idle: begin
                        // Every command here gets its own response, good or bad
                        if (cmd_fire)
                                state_next = st_respond_low;
                end
                st_respond_low: begin
                        if (rsp_ready)
                                state_next = err_q ? st_idle : st_wait_high;
                end
                st_wait_high: begin
                        // Bad second word skips the engine entirely
                        if (cmd_fire)
                                state_next = high_ok ? st_route : st_respond_high;
                end
                st_route: begin
                        // Hold until the selected engine takes the pointer
                        if (desc_ready[chan_q])
                                state_next = st_respond_high;
                end
                st_respond_high: begin
                        if (rsp_ready)
                                state_next = st_idle;
                end
                default: begin
                        state_next = st_idle;
                end
                endcase
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        state  <= st_idle;
                        chan_q <= '0;
                        err_q  <= 1'b0;
                end else begin
                        state <= state_next;
                        if (cmd_fire && state == st_idle) begin
                                err_q <= !low_ok;
                                // Channel is only taken from a good LOW write
                                if (low_ok)
                                        chan_q <= dec_chan;
                        end
                        if (cmd_fire && state == st_wait_high)
                                err_q <= !high_ok;
                end
        end

        // ==============================================================
        // Handshake and router controls
        // ==============================================================

        assign cmd_ready = (state == st_idle) || (state == st_wait_high);
        assign rsp_valid = (state == st_respond_low) || (state == st_respond_high);
        assign rsp_error = err_q;

        // Capture strobes for the data words, good writes only
        assign load_low  = cmd_fire && (state == st_idle) && low_ok;
        assign load_high = cmd_fire && (state == st_wait_high) && high_ok;
        assign wdata     = cmd.wdata;

        assign route_active = (state == st_route);
        assign route_chan   = chan_q;

        // Parent uses this to take the response from here; never on a LOW reply
        assign kickoff_hit = ((state == st_route) || (state == st_respond_high)) && !err_q;

        // ==============================================================
        // Assertions
        // ==============================================================

        // Command and response phases never overlap
        a_no_cmd_rsp_overlap: assert property (
                @(posedge clk) disable iff (reset)
                !(cmd_ready && rsp_valid));

        // Routing is only reached after a clean pair
        a_route_no_error: assert property (
                @(posedge clk) disable iff (reset)
                route_active |-> !err_q);

endmodule

`default_nettype wire

//--- common/desc_kick_pkg.sv
// Types shared by the kick-off router: widths, command struct, FSM states, word select
`default_nettype none

`include "desc_kick_settings.svh"

package desc_kick_pkg;

        // ==============================================================
        // Width types
        // ==============================================================

        typedef logic [`DK_ADDR_WIDTH-1:0]           cmd_addr_t;
        typedef logic [`DK_DATA_WIDTH-1:0]           cmd_data_t;
        typedef logic [`DK_DESC_ADDR_WIDTH-1:0]      desc_addr_t;
        // Channel number, 3 bits for eight engines
        typedef logic [$clog2(`DK_NUM_CHANNELS)-1:0] chan_id_t;
        // One bit per engine
        typedef logic [`DK_NUM_CHANNELS-1:0]         chan_mask_t;

        // ==============================================================
        // Command bundle
        // ==============================================================

        // Request from the register block, 65 bits
        typedef struct packed {
                cmd_addr_t addr;
                cmd_data_t wdata;
                logic      write;
        } apb_cmd_t;

        // Pair-tracking FSM
        typedef enum logic [2:0] {
                st_idle         = 3'd0,
                st_respond_low  = 3'd1,
                st_wait_high    = 3'd2,
                st_route        = 3'd3,
                st_respond_high = 3'd4
        } kick_state_t;

        // Address bit 2 picks the half of the descriptor pointer
        typedef enum logic {
                word_low  = 1'b0,
                word_high = 1'b1
        } word_sel_t;

endpackage

`default_nettype wire

//--- common/desc_kick_settings.svh
// Build-time constants for the descriptor kick-off router: channel count, widths, window
`ifndef DESC_KICK_SETTINGS_SVH
`define DESC_KICK_SETTINGS_SVH

// ======================================================================
// Channel count
// ======================================================================

// One DMA descriptor engine per channel
`define DK_NUM_CHANNELS 8

// ======================================================================
// Widths
// ======================================================================

// Command address and data words from the register block
`define DK_ADDR_WIDTH 32
`define DK_DATA_WIDTH 32

// Assembled descriptor pointer, HIGH word above LOW word
`define DK_DESC_ADDR_WIDTH 64

// ======================================================================
// Register window
// ======================================================================

// Low address bits that take part in the range check
`define DK_DECODE_BITS 12

// Two 32-bit words per channel, 0x40 for eight channels
`define DK_WINDOW_BYTES (`DK_NUM_CHANNELS * 8)

`endif
